//--- Bender.yml
package:
  name: snes_cart_loader

sources:
  - files:
      - snes_cart_pkg.sv
      - load_bus_if.sv
      - cart_download_decode.sv
      - rom_header_parser.sv
      - ram_clear_fill.sv
      - backup_sector_seq.sv
      - snes_cart_loader.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - snes_cart_loader_asserts.sv
      - snes_cart_loader_tb.sv

//--- backup_sector_seq.sv
//==================================================
// Save RAM sector transfers to and from the SD image
//==================================================
`timescale 1ns/10ps

module backup_sector_seq import snes_cart_pkg::*; (
	input  logic      clk_sys,
	input  logic      RESET,
	load_bus_if.sink  bus,
	input  mem_mask_t ram_mask,
	input  logic      img_mounted,
	input  logic      img_readonly,
	input  logic      img_present,
	input  logic      bk_load_req,
	input  logic      bk_save_req,
	input  logic      sd_ack,
	output sd_lba_t   sd_lba,
	output logic      sd_rd,
	output logic      sd_wr,
	output logic      bk_busy,
	output logic      bk_loading,
	output logic      bk_ena
);

	bk_state_e state;
	logic      old_load;
	logic      old_save;
	logic      old_ack;
	logic      load_rise;
	logic      save_rise;
	logic      ack_rise;
	logic      ack_fall;
	sd_lba_t   lba_last;

	// Last sector index of the save RAM
	assign lba_last = sd_lba_t'(ram_mask >> SECTOR_SHIFT);

	assign load_rise = bk_load_req & bk_ena & ~old_load;
	assign save_rise = bk_save_req & bk_ena & ~old_save;
	assign ack_rise  = sd_ack & ~old_ack;
	assign ack_fall  = ~sd_ack & old_ack;
	assign bk_busy   = (state != BK_IDLE);

	//==================================================
	// Backup enable
	//==================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			bk_ena <= 1'b0;
		end else if (bus.load_start) begin
			bk_ena <= 1'b0;
		end else if (bus.cart_active && img_mounted && !img_readonly) begin
			// Save image is mounted by the end of the download
			bk_ena <= |ram_mask;
		end
	end

	//==================================================
	// Sector sequencer
	//==================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state      <= BK_IDLE;
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_ack    <= 1'b0;
			bk_loading <= 1'b0;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
		end else begin
			old_load <= bk_load_req & bk_ena;
			old_save <= bk_save_req & bk_ena;
			old_ack  <= sd_ack;

			case (state)
				BK_IDLE: begin
					if (bus.load_end && img_present) begin
						// Auto load once the cartridge is in
						state      <= BK_REQ;
						bk_loading <= 1'b1;
						sd_lba     <= '0;
						sd_rd      <= 1'b1;
						sd_wr      <= 1'b0;
					end else if (load_rise || save_rise) begin
						state      <= BK_REQ;
						bk_loading <= load_rise;
						sd_lba     <= '0;
						sd_rd      <= load_rise;
						sd_wr      <= ~load_rise;
					end
				end
				BK_REQ: begin
					if (ack_rise) begin
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= BK_WAIT_END;
					end
				end
				BK_WAIT_END: begin
					if (ack_fall) begin
						if (sd_lba >= lba_last) begin
							state      <= BK_IDLE;
							bk_loading <= 1'b0;
						end else begin
							state  <= BK_REQ;
							sd_lba <= sd_lba + 1'b1;
							sd_rd  <= bk_loading;
							sd_wr  <= ~bk_loading;
						end
					end
				end
				default: state <= BK_IDLE;
			endcase
		end
	end

endmodule

//--- cart_download_decode.sv
//==================================================
// Download index decode and load start/end pulses
//==================================================
`timescale 1ns/10ps

module cart_download_decode import snes_cart_pkg::*; (
	input  logic      clk_sys,
	input  logic      RESET,
	input  logic      ioctl_download,
	input  dl_index_t ioctl_index,
	input  logic      ioctl_wr,
	input  dl_addr_t  ioctl_addr,
	input  dl_data_t  ioctl_dout,
	load_bus_if.src   bus
);

	logic cart_active;
	logic cart_active_q;
	logic load_start;
	logic load_end;

	// Upper index bits select the file slot, ignored here
	assign cart_active = ioctl_download & (ioctl_index[5:0] == CART_INDEX);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_active_q <= 1'b0;
			load_start    <= 1'b0;
			load_end      <= 1'b0;
		end else begin
			cart_active_q <= cart_active;
			load_start    <= cart_active & ~cart_active_q;
			load_end      <= ~cart_active & cart_active_q;
		end
	end

	//==================================================
	// Bus drive
	//==================================================
	assign bus.cart_active = cart_active;
	assign bus.load_start  = load_start;
	assign bus.load_end    = load_end;

	// Other download slots must not touch the header logic
	assign bus.wr   = ioctl_wr & cart_active;
	assign bus.addr = ioctl_addr;
	assign bus.data = ioctl_dout;

endmodule

//--- load_bus_if.sv
//==================================================
// Decoded cartridge download stream
//==================================================
`timescale 1ns/10ps

interface load_bus_if import snes_cart_pkg::*; ();

	// Level while a cartridge image is streaming in
	logic     cart_active;
	// Single cycle edges of cart_active
	logic     load_start;
	logic     load_end;
	// Write strobe already qualified by cart_active
	logic     wr;
	dl_addr_t addr;
	dl_data_t data;

	modport src (
		output cart_active,
		output load_start,
		output load_end,
		output wr,
		output addr,
		output data
	);

	modport sink (
		input cart_active,
		input load_start,
		input load_end,
		input wr,
		input addr,
		input data
	);

endinterface

//--- ram_clear_fill.sv
//==================================================
// Work RAM clear sequencer and start-up pattern
//==================================================
`timescale 1ns/10ps

module ram_clear_fill import snes_cart_pkg::*; #(
	parameter int FILL_ADDR_W = FILL_ADDR_W_DEF
) (
	input  logic                   clk_sys,
	input  logic                   RESET,
	load_bus_if.sink               bus,
	input  logic [1:0]             wram_init,
	output logic                   clearing,
	output logic                   fill_we,
	output logic [FILL_ADDR_W-1:0] fill_addr,
	output fill_byte_t             fill_data
);

	// Write slot when low, address step when high
	logic fill_wait;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			clearing  <= 1'b0;
			fill_wait <= 1'b0;
			fill_addr <= '0;
		end else begin
			if (bus.load_start) begin
				clearing <= 1'b1;
			end
			// Stop right after the top address is written
			if (fill_we && (&fill_addr)) begin
				clearing <= 1'b0;
			end

			if (clearing) begin
				fill_wait <= ~fill_wait;
				if (fill_wait) begin
					fill_addr <= fill_addr + 1'b1;
				end
			end else begin
				fill_wait <= 1'b0;
				fill_addr <= '0;
			end
		end
	end

	assign fill_we = clearing & ~fill_wait;

	//==================================================
	// Fill pattern
	//==================================================
	always_comb begin
		case (wram_init)
			2'd0:    fill_data = (fill_addr[8] ^ fill_addr[2]) ? FILL_SNES2_SET : FILL_SNES2_CLR;
			2'd1:    fill_data = (fill_addr[9] ^ fill_addr[0]) ? FILL_SNES1_SET : FILL_SNES1_CLR;
			2'd2:    fill_data = FILL_SD2SNES;
			default: fill_data = FILL_ONES;
		endcase
	end

endmodule

//--- rom_header_parser.sv
//==================================================
// SNES header capture: mapper type, ROM/RAM masks
// and video region
//==================================================
`timescale 1ns/10ps

module rom_header_parser import snes_cart_pkg::*; (
	input  logic       clk_sys,
	input  logic       RESET,
	load_bus_if.sink   bus,
	input  logic [2:0] hdr_mode,
	input  logic [1:0] region_sel,
	output rom_type_t  rom_type,
	output mem_mask_t  rom_mask,
	output mem_mask_t  ram_mask,
	output logic       pal
);

	size_code_t rom_size;
	size_code_t ram_size;
	logic       rom_region;
	dl_addr_t   hdr_size_addr;
	logic       hdr_fixed;

	// Forced header layouts point at a fixed size word
	always_comb begin
		hdr_size_addr = HDR_LOROM_SIZE;
		hdr_fixed     = 1'b0;
		case (hdr_mode)
			3'd2: begin
				hdr_size_addr = HDR_LOROM_SIZE;
				hdr_fixed     = 1'b1;
			end
			3'd3: begin
				hdr_size_addr = HDR_HIROM_SIZE;
				hdr_fixed     = 1'b1;
			end
			3'd4: begin
				hdr_size_addr = HDR_EXHIROM_SIZE;
				hdr_fixed     = 1'b1;
			end
			default: begin
				hdr_size_addr = HDR_LOROM_SIZE;
				hdr_fixed     = 1'b0;
			end
		endcase
	end

	//==================================================
	// Capture on download writes
	//==================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_type   <= '0;
			rom_size   <= DEF_ROM_SIZE;
			ram_size   <= '0;
			rom_region <= 1'b0;
			pal        <= 1'b0;
		end else if (bus.cart_active) begin
			if (bus.wr) begin
				if (bus.addr == '0) begin
					rom_size <= DEF_ROM_SIZE;
					ram_size <= '0;
					// Auto mode: loader puts the size codes in the low byte
					if (hdr_mode == 3'd0 && bus.data[7:0] != 8'h00) begin
						{ram_size, rom_size} <= bus.data[7:0];
					end
					case (hdr_mode)
						3'd1:    rom_type <= 8'd0;
						3'd2:    rom_type <= 8'd0;
						3'd3:    rom_type <= 8'd1;
						3'd4:    rom_type <= 8'd2;
						default: rom_type <= bus.data[15:8];
					endcase
				end

				if (bus.addr == dl_addr_t'(2)) begin
					rom_region <= bus.data[8];
				end

				if (hdr_fixed && bus.addr == hdr_size_addr) begin
					rom_size <= bus.data[11:8];
				end
				if (hdr_fixed && bus.addr == hdr_size_addr + HDR_RAM_OFS) begin
					ram_size <= bus.data[3:0];
				end
			end
		end else begin
			// Region held steady while an image loads
			pal <= (region_sel == 2'd0) ? rom_region : region_sel[1];
		end
	end

	// Size code n means 1 KiB << n
	assign rom_mask = (mem_mask_t'(1024) << rom_size) - mem_mask_t'(1);
	assign ram_mask = (ram_size != '0) ? (mem_mask_t'(1024) << ram_size) - mem_mask_t'(1) : '0;

endmodule

//--- snes_cart_loader.f
snes_cart_pkg.sv
load_bus_if.sv
cart_download_decode.sv
rom_header_parser.sv
ram_clear_fill.sv
backup_sector_seq.sv
snes_cart_loader.sv
tb_clock_gen.sv
snes_cart_loader_asserts.sv
snes_cart_loader_tb.sv

//--- snes_cart_loader.sv
//==================================================
// Cartridge load control top: download decode,
// header parse, WRAM clear, backup RAM and core reset
//==================================================
`timescale 1ns/10ps

module snes_cart_loader import snes_cart_pkg::*; #(
	parameter int FILL_ADDR_W = FILL_ADDR_W_DEF
) (
	input  logic                   clk_sys,
	input  logic                   RESET,
	// Host download stream
	input  logic                   ioctl_download,
	input  dl_index_t              ioctl_index,
	input  logic                   ioctl_wr,
	input  dl_addr_t               ioctl_addr,
	input  dl_data_t               ioctl_dout,
	// Menu options
	input  logic [2:0]             hdr_mode,
	input  logic [1:0]             region_sel,
	input  logic [1:0]             wram_init,
	// SD image
	input  logic                   img_mounted,
	input  logic                   img_readonly,
	input  logic                   img_present,
	input  logic                   bk_load_req,
	input  logic                   bk_save_req,
	input  logic                   sd_ack,
	// Cartridge setup
	output rom_type_t              rom_type,
	output mem_mask_t              rom_mask,
	output mem_mask_t              ram_mask,
	output logic                   pal,
	// WRAM fill port
	output logic                   clearing,
	output logic                   fill_we,
	output logic [FILL_ADDR_W-1:0] fill_addr,
	output fill_byte_t             fill_data,
	// SD requests
	output sd_lba_t                sd_lba,
	output logic                   sd_rd,
	output logic                   sd_wr,
	output logic                   bk_busy,
	output logic                   bk_ena,
	output logic                   core_reset
);

	logic bk_loading;

	load_bus_if bus_i ();

	cart_download_decode decode_i (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.bus            (bus_i.src)
	);

	rom_header_parser header_i (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.bus        (bus_i.sink),
		.hdr_mode   (hdr_mode),
		.region_sel (region_sel),
		.rom_type   (rom_type),
		.rom_mask   (rom_mask),
		.ram_mask   (ram_mask),
		.pal        (pal)
	);

	ram_clear_fill #(
		.FILL_ADDR_W (FILL_ADDR_W)
	) fill_i (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.bus       (bus_i.sink),
		.wram_init (wram_init),
		.clearing  (clearing),
		.fill_we   (fill_we),
		.fill_addr (fill_addr),
		.fill_data (fill_data)
	);

	backup_sector_seq backup_i (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.bus          (bus_i.sink),
		.ram_mask     (ram_mask),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_present  (img_present),
		.bk_load_req  (bk_load_req),
		.bk_save_req  (bk_save_req),
		.sd_ack       (sd_ack),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.bk_busy      (bk_busy),
		.bk_loading   (bk_loading),
		.bk_ena       (bk_ena)
	);

	// Core held in reset while memory contents are being replaced
	assign core_reset = RESET | bus_i.cart_active | clearing | bk_loading;

endmodule

//--- snes_cart_loader_asserts.sv
//==================================================
// Concurrent checks on fill, SD handshake and reset
//==================================================
`timescale 1ns/10ps

module snes_cart_loader_asserts #(
	parameter int FILL_ADDR_W = 10
) (
	input logic                   clk_sys,
	input logic                   RESET,
	input logic                   clearing,
	input logic                   fill_we,
	input logic [FILL_ADDR_W-1:0] fill_addr,
	input logic                   sd_rd,
	input logic                   sd_wr,
	input logic                   sd_ack,
	input logic                   bk_busy,
	input logic                   bk_ena,
	input logic                   bk_loading,
	input logic                   core_reset
);

	int fail_count;

	initial fail_count = 0;

	// Outputs quiet in the first cycle after reset
	a_reset_quiet: assert property (@(posedge clk_sys)
		$fell(RESET) |-> !(clearing || fill_we || sd_rd || sd_wr || bk_busy || bk_ena))
	else begin
		$error("Outputs active directly after reset");
		fail_count++;
	end

	a_fill_spacing: assert property (@(posedge clk_sys) disable iff (RESET)
		fill_we |=> !fill_we)
	else begin
		$error("fill_we high in two consecutive cycles");
		fail_count++;
	end

	// Clear ends together with the top address write
	a_clear_end: assert property (@(posedge clk_sys) disable iff (RESET)
		$fell(clearing) |-> $past(fill_we && (&fill_addr)))
	else begin
		$error("clearing fell without a write to the last address");
		fail_count++;
	end

	a_sd_exclusive: assert property (@(posedge clk_sys) disable iff (RESET)
		!(sd_rd && sd_wr))
	else begin
		$error("sd_rd and sd_wr high together");
		fail_count++;
	end

	a_req_drop: assert property (@(posedge clk_sys) disable iff (RESET)
		$rose(sd_ack) |=> !(sd_rd || sd_wr))
	else begin
		$error("SD request still high one cycle after sd_ack rose");
		fail_count++;
	end

	a_core_hold: assert property (@(posedge clk_sys) disable iff (RESET)
		(clearing || bk_loading) |-> core_reset)
	else begin
		$error("core_reset low during clear or backup load");
		fail_count++;
	end

endmodule

//--- snes_cart_loader_tb.sv
//==================================================
// Testbench: header decode, WRAM fill, region
// and backup RAM sector transfers
//==================================================
`timescale 1ns/10ps

module snes_cart_loader_tb import snes_cart_pkg::*; ();

	logic       clk_sys;
	logic       RESET;
	logic       ioctl_download;
	dl_index_t  ioctl_index;
	logic       ioctl_wr;
	dl_addr_t   ioctl_addr;
	dl_data_t   ioctl_dout;
	logic [2:0] hdr_mode;
	logic [1:0] region_sel;
	logic [1:0] wram_init;
	logic       img_mounted;
	logic       img_readonly;
	logic       img_present;
	logic       bk_load_req;
	logic       bk_save_req;
	logic       sd_ack;
	rom_type_t  rom_type;
	mem_mask_t  rom_mask;
	mem_mask_t  ram_mask;
	logic       pal;
	logic       clearing;
	logic       fill_we;
	logic [9:0] fill_addr;
	fill_byte_t fill_data;
	sd_lba_t    sd_lba;
	logic       sd_rd;
	logic       sd_wr;
	logic       bk_busy;
	logic       bk_ena;
	logic       core_reset;

	integer     seed;
	int         err_count;
	int         rd_count;
	int         wr_count;
	int         fill_hits [1024];
	// Reference state built from the header rules
	size_code_t exp_rom_code;
	size_code_t exp_ram_code;
	rom_type_t  exp_type;
	logic       exp_region;

	tb_clock_gen clk_gen_i (
		.clk_sys (clk_sys),
		.RESET   (RESET)
	);

	snes_cart_loader #(
		.FILL_ADDR_W (10)
	) dut_i (
		.*
	);

	bind snes_cart_loader snes_cart_loader_asserts #(
		.FILL_ADDR_W (FILL_ADDR_W)
	) asserts_i (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.clearing   (clearing),
		.fill_we    (fill_we),
		.fill_addr  (fill_addr),
		.sd_rd      (sd_rd),
		.sd_wr      (sd_wr),
		.sd_ack     (sd_ack),
		.bk_busy    (bk_busy),
		.bk_ena     (bk_ena),
		.bk_loading (bk_loading),
		.core_reset (core_reset)
	);

	//==================================================
	// Reference rules and helpers
	//==================================================
	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got == exp) else begin
			$display("[ERROR] %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
			err_count++;
		end
	endtask

	// Size code n stands for 1 KiB << n bytes
	function automatic mem_mask_t size_mask(input size_code_t code);
		longint bytes;
		bytes = longint'(1024) << code;
		return mem_mask_t'(bytes - 1);
	endfunction

	function automatic fill_byte_t fill_pattern(input logic [1:0] init, input logic [9:0] a);
		case (init)
			2'd0:    return (a[8] ^ a[2]) ? 8'h66 : 8'h99;
			2'd1:    return (a[9] ^ a[0]) ? 8'hFF : 8'h00;
			2'd2:    return 8'h55;
			default: return 8'hFF;
		endcase
	endfunction

	function automatic dl_addr_t size_word_addr(input logic [2:0] mode);
		if (mode == 3'd3)
			return HDR_HIROM_SIZE;
		if (mode == 3'd4)
			return HDR_EXHIROM_SIZE;
		return HDR_LOROM_SIZE;
	endfunction

	// One download write, then the masks and type one cycle later
	task automatic write_word(input dl_addr_t addr, input dl_data_t data);
		dl_addr_t sz;
		sz = size_word_addr(hdr_mode);
		if (addr == '0) begin
			exp_rom_code = DEF_ROM_SIZE;
			exp_ram_code = '0;
			if (hdr_mode == 3'd0 && data[7:0] != 8'h00)
				{exp_ram_code, exp_rom_code} = data[7:0];
			case (hdr_mode)
				3'd0:    exp_type = data[15:8];
				3'd3:    exp_type = 8'd1;
				3'd4:    exp_type = 8'd2;
				default: exp_type = 8'd0;
			endcase
		end
		if (addr == dl_addr_t'(2))
			exp_region = data[8];
		if (hdr_mode >= 3'd2 && hdr_mode <= 3'd4) begin
			if (addr == sz)
				exp_rom_code = data[11:8];
			if (addr == sz + HDR_RAM_OFS)
				exp_ram_code = data[3:0];
		end
		ioctl_wr   = 1'b1;
		ioctl_addr = addr;
		ioctl_dout = data;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		check_val("rom_type", rom_type, exp_type);
		check_val("rom_mask", rom_mask, size_mask(exp_rom_code));
		check_val("ram_mask", ram_mask, (exp_ram_code == '0) ? '0 : size_mask(exp_ram_code));
		@(negedge clk_sys);
	endtask

	task automatic load_cart(input logic [2:0] mode, input size_code_t rom_code,
			input size_code_t ram_code, input logic [1:0] init, input logic present);
		dl_addr_t sz;
		sz = size_word_addr(mode);
		for (int i = 0; i < 1024; i++)
			fill_hits[i] = 0;
		hdr_mode       = mode;
		wram_init      = init;
		img_present    = present;
		// Slot bits above the low six are ignored
		ioctl_index    = 8'h40;
		ioctl_download = 1'b1;
		@(negedge clk_sys);
		write_word('0, {rom_type_t'($random(seed)), ram_code, rom_code});
		write_word(dl_addr_t'(2), dl_data_t'($random(seed)));
		write_word(sz, {4'($random(seed)), rom_code, 8'($random(seed))});
		write_word(sz + HDR_RAM_OFS, {12'($random(seed)), ram_code});
		ioctl_download = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic check_region();
		for (int rs = 0; rs < 4; rs++) begin
			region_sel = 2'(rs);
			@(negedge clk_sys);
			check_val("pal", pal, (rs == 0) ? exp_region : rs[1]);
		end
	endtask

	task automatic wait_clear_done();
		int n;
		n = 0;
		while (clearing && n < 5000) begin
			@(negedge clk_sys);
			n++;
		end
		if (clearing) begin
			$display("Timeout at %0t: WRAM clear did not finish", $time);
			err_count++;
		end
		for (int i = 0; i < 1024; i++)
			check_val($sformatf("fill_hits[%0d]", i), fill_hits[i], 1);
	endtask

	task automatic wait_backup_done();
		int n;
		n = 0;
		while (!bk_busy && n < 20) begin
			@(negedge clk_sys);
			n++;
		end
		n = 0;
		while (bk_busy && n < 2000) begin
			@(negedge clk_sys);
			n++;
		end
		if (bk_busy || n == 0) begin
			$display("Timeout at %0t: backup transfer did not start or finish", $time);
			err_count++;
		end
	endtask

	//==================================================
	// Monitors and SD model
	//==================================================
	always @(negedge clk_sys) begin
		if (!RESET && fill_we) begin
			fill_hits[fill_addr]++;
			check_val("fill_data", fill_data, fill_pattern(wram_init, fill_addr));
		end
	end

	// Ack 3 to 6 cycles after a request, held for 4 cycles
	initial begin : sd_ack_model
		int delay;
		sd_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if ((sd_rd || sd_wr) && !sd_ack) begin
				check_val("sd_lba", sd_lba, rd_count + wr_count);
				if (sd_rd)
					rd_count++;
				else
					wr_count++;
				delay = 3 + int'($unsigned($random(seed)) % 4);
				repeat (delay) @(negedge clk_sys);
				sd_ack = 1'b1;
				repeat (4) @(negedge clk_sys);
				sd_ack = 1'b0;
			end
		end
	end

	initial begin
		#2_000_000;
		$display("Timeout: simulation did not complete in time");
		$display("Simulation failed");
		$finish;
	end

	//==================================================
	// Main sequence
	//==================================================
	initial begin : stimulus
		int n;
		seed           = 85150;
		err_count      = 0;
		rd_count       = 0;
		wr_count       = 0;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		hdr_mode       = '0;
		region_sel     = '0;
		wram_init      = '0;
		img_mounted    = 1'b1;
		img_readonly   = 1'b0;
		img_present    = 1'b0;
		bk_load_req    = 1'b0;
		bk_save_req    = 1'b0;
		// Reset is sampled on the rising edge where it is stable
		n = 0;
		while (RESET !== 1'b0 && n < 20) begin
			@(posedge clk_sys);
			n++;
		end
		if (RESET !== 1'b0) begin
			$display("Timeout at %0t: reset was not released", $time);
			err_count++;
		end
		@(negedge clk_sys);

		// Every header mode, each fill pattern
		for (int m = 0; m < 5; m++) begin
			load_cart(3'(m), size_code_t'($random(seed)), size_code_t'($random(seed)),
				2'(m % 4), 1'b0);
			check_region();
			wait_clear_done();
		end

		// Automatic load of a small save RAM
		rd_count = 0;
		wr_count = 0;
		load_cart(3'd2, size_code_t'($random(seed)),
			size_code_t'(1 + $unsigned($random(seed)) % 3), 2'd3, 1'b1);
		wait_backup_done();
		check_val("sd_rd count", rd_count, (size_mask(exp_ram_code) >> SECTOR_SHIFT) + 1);
		check_val("sd_wr count", wr_count, 0);
		wait_clear_done();

		rd_count    = 0;
		wr_count    = 0;
		bk_save_req = 1'b1;
		wait_backup_done();
		bk_save_req = 1'b0;
		check_val("sd_wr count", wr_count, (size_mask(exp_ram_code) >> SECTOR_SHIFT) + 1);
		check_val("sd_rd count", rd_count, 0);

		// No save RAM, so requests are ignored
		rd_count = 0;
		wr_count = 0;
		load_cart(3'd2, size_code_t'($random(seed)), '0, 2'd1, 1'b0);
		check_val("bk_ena", bk_ena, 1'b0);
		bk_save_req = 1'b1;
		repeat (20) @(negedge clk_sys);
		bk_save_req = 1'b0;
		check_val("sd_wr count", wr_count, 0);
		check_val("sd_rd count", rd_count, 0);
		check_val("bk_busy", bk_busy, 1'b0);
		wait_clear_done();

		$display("Errors: %0d check, %0d assertion", err_count, dut_i.asserts_i.fail_count);
		if (err_count == 0 && dut_i.asserts_i.fail_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- snes_cart_pkg.sv
//==================================================
// Shared widths, header offsets, WRAM fill values
// and the backup sequencer state for the cart loader
//==================================================
package snes_cart_pkg;

	//==================================================
	// Widths
	//==================================================
	typedef logic [24:0] dl_addr_t;
	typedef logic [15:0] dl_data_t;
	typedef logic [7:0]  dl_index_t;
	typedef logic [23:0] mem_mask_t;
	typedef logic [7:0]  rom_type_t;
	typedef logic [3:0]  size_code_t;
	typedef logic [31:0] sd_lba_t;
	typedef logic [7:0]  fill_byte_t;

	// Low 6 bits of the download index for a cartridge image
	localparam logic [5:0] CART_INDEX = 6'd0;

	//==================================================
	// Header locations
	//==================================================
	// Copier header in front of the image
	localparam dl_addr_t HDR_COPIER = 25'h200;

	localparam dl_addr_t HDR_LOROM_SIZE   = 25'h7FD6 + HDR_COPIER;
	localparam dl_addr_t HDR_HIROM_SIZE   = 25'hFFD6 + HDR_COPIER;
	localparam dl_addr_t HDR_EXHIROM_SIZE = 25'h40FFD6 + HDR_COPIER;

	// RAM size word sits right after the ROM size word
	localparam dl_addr_t HDR_RAM_OFS = 25'd2;

	localparam size_code_t DEF_ROM_SIZE = 4'hC;

	//==================================================
	// WRAM clear
	//==================================================
	localparam int FILL_ADDR_W_DEF = 18;

	// 9966 pattern
	localparam fill_byte_t FILL_SNES2_SET = 8'h66;
	localparam fill_byte_t FILL_SNES2_CLR = 8'h99;
	// 00FF pattern
	localparam fill_byte_t FILL_SNES1_SET = 8'hFF;
	localparam fill_byte_t FILL_SNES1_CLR = 8'h00;
	localparam fill_byte_t FILL_SD2SNES   = 8'h55;
	localparam fill_byte_t FILL_ONES      = 8'hFF;

	// 512 byte sectors
	localparam int SECTOR_SHIFT = 9;

	typedef enum logic [1:0] {
		BK_IDLE,
		BK_REQ,
		BK_WAIT_END
	} bk_state_e;

endpackage

//--- tb_clock_gen.sv
//==================================================
// Testbench clock and power-on reset
//==================================================
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int PERIOD       = 10,
	parameter int RESET_CYCLES = 2
) (
	output logic clk_sys,
	output logic RESET
);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD / 2) clk_sys = ~clk_sys;
	end

	// Release on a falling edge, same as the stimulus
	initial begin
		RESET = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		RESET = 1'b0;
	end

endmodule
